/* sources.f */
common/opp_data_pkg.sv
common/opp_cfg_pkg.sv
output_stage/opp_apb_regs.sv
output_stage/opp_sequencer.sv
output_stage/opp_latency_timer.sv
output_stage/opp_accumulator.sv
output_stage/opp_limiter.sv
source/output_preprocessor_top.sv
bench/output_preprocessor_properties.sv
bench/output_preprocessor_tb.sv

/* run_sim.sh */
#!/bin/sh

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module output_preprocessor_tb -Mdir "$BUILD" -o sim_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD/sim_tb" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q -F '*** TEST PASSED ***' "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* bench/output_preprocessor_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module output_preprocessor_tb;

	import opp_data_pkg::*;
	import opp_cfg_pkg::*;

	localparam int TIMEOUT_CYCLES = 2000;        // 80 x (L+3+4) + 40 x 3 + margin
	localparam int WAIT_LIMIT     = 16;          // per handshake

	logic                    clk_in;
	logic                    reset_in;
	apb_req_t                apb_req;
	logic [31:0]             prdata;
	logic signed [SUM_W-1:0] pid_sum;
	logic                    data_valid;
	logic                    lock_en;
	logic                    in_ready;
	logic signed [OUT_W-1:0] data_out;
	logic                    data_valid_out;

	opp_params_t             shadow_m;           // model shadow set
	opp_params_t             active_m;           // model active set
	logic signed [OUT_W-1:0] prev_m;             // model previous output
	logic [31:0]             lfsr;
	int                      cycles     = 0;
	int                      errors     = 0;
	int                      valid_seen = 0;     // pulses on data_valid_out
	int                      accepted   = 0;     // words the model expects
	int                      assert_fails;

	output_preprocessor_top i_dut (.*);

	initial begin
		clk_in = 1'b0;
		forever #20 clk_in = ~clk_in;
	end

	always @(posedge clk_in) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the DUT stopped responding", cycles);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	always @(negedge clk_in) begin
		if (!reset_in && data_valid_out) valid_seen <= valid_seen + 1;
	end

	////////////////////
	// random source
	////////////////////

	function automatic logic [31:0] galois_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = galois_step(lfsr);            // one step per bit
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic signed [SUM_W-1:0] small_sample();
		logic [31:0] r;
		r = random_bits(9);
		return SUM_W'($signed(r[8:0]));          // -256 .. 255
	endfunction

	function automatic logic signed [SUM_W-1:0] large_sample(input logic negative);
		logic [31:0]             r;
		logic signed [SUM_W-1:0] v;
		r = random_bits(19);
		v = SUM_W'({1'b1, r[18:0]});             // 2^19 .. 2^20-1
		return negative ? -v : v;
	endfunction

	// previous output plus scaled sample, or init when unlocked, then max, then min
	function automatic logic signed [OUT_W-1:0] expected_word(
		input logic signed [SUM_W-1:0] s, input logic lock);
		longint cand;
		if (lock) cand = longint'(prev_m) + longint'(s) * longint'($signed(active_m.multiplier));
		else cand = longint'($signed(active_m.output_init));
		if (cand > longint'($signed(active_m.output_max))) cand = active_m.output_max;
		if (cand < longint'($signed(active_m.output_min))) cand = active_m.output_min;
		return OUT_W'(cand);
	endfunction

	task automatic compare_word(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got == exp) else begin
			errors++;
			$display("ERR %0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
		end
	endtask

	////////////////////
	// apb access
	////////////////////

	task automatic apb_write(input logic [4:0] addr, input logic [31:0] data);
		@(posedge clk_in);
		apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
		@(posedge clk_in);
		apb_req.penable <= 1'b1;
		@(posedge clk_in);                       // write lands at this edge
		apb_req <= '0;
		case (addr)
			REG_MAX:  shadow_m.output_max  = data[OUT_W-1:0];
			REG_MIN:  shadow_m.output_min  = data[OUT_W-1:0];
			REG_INIT: shadow_m.output_init = data[OUT_W-1:0];
			REG_MULT: shadow_m.multiplier  = data[MLT_W-1:0];
			REG_APPLY: if (data[0]) begin
				active_m = shadow_m;             // commit and restart from init
				prev_m   = shadow_m.output_init;
			end
			default: ;
		endcase
	endtask

	task automatic apb_read(input logic [4:0] addr, output logic [31:0] data);
		@(posedge clk_in);
		apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
		@(posedge clk_in);
		apb_req.penable <= 1'b1;
		@(negedge clk_in);                       // access cycle
		data = prdata;
		@(posedge clk_in);
		apb_req <= '0;
	endtask

	task automatic check_readback();
		logic [31:0] d;
		apb_read(REG_MAX, d);
		compare_word("prdata", d, 32'($signed(shadow_m.output_max)));
		apb_read(REG_MIN, d);
		compare_word("prdata", d, 32'($signed(shadow_m.output_min)));
		apb_read(REG_INIT, d);
		compare_word("prdata", d, 32'($signed(shadow_m.output_init)));
		apb_read(REG_MULT, d);
		compare_word("prdata", d, 32'($signed(shadow_m.multiplier)));
		apb_read(REG_APPLY, d);
		compare_word("prdata", d, 32'd0);
	endtask

	////////////////////
	// samples
	////////////////////

	// busy = number of extra offers made while the sequencer is computing
	task automatic send_sample(input logic signed [SUM_W-1:0] s, input logic lock,
		input int busy);
		logic signed [OUT_W-1:0] exp;
		int                      n;
		logic                    seen;
		@(posedge clk_in);
		pid_sum    <= s;
		lock_en    <= lock;
		data_valid <= 1'b1;
		@(negedge clk_in);
		if (!in_ready) begin
			errors++;
			$display("DUT not ready for a new sample at %0t", $time);
		end
		@(posedge clk_in);                       // acceptance edge
		exp = expected_word(s, lock);
		accepted++;
		if (busy == 0) data_valid <= 1'b0;
		else pid_sum <= SUM_W'(random_bits(SUM_W));
		n    = 0;
		seen = 1'b0;
		while (!seen && n < WAIT_LIMIT) begin
			@(negedge clk_in);
			n++;
			seen = data_valid_out;
			if (!seen) begin
				@(posedge clk_in);
				if (n >= busy) data_valid <= 1'b0;
				else pid_sum <= SUM_W'(random_bits(SUM_W)); // offer while busy
			end
		end
		if (!seen) begin
			errors++;
			$display("no data_valid_out within %0d cycles of acceptance", WAIT_LIMIT);
		end else begin
			if (n != COMP_LATENCY + 1) begin
				errors++;
				$display("data_valid_out came %0d cycles after acceptance, not %0d",
				         n, COMP_LATENCY + 1);
			end
			compare_word("data_out", 32'(data_out), 32'(exp));
		end
		prev_m = exp;                            // latched in DONE
		n = 0;
		while (!in_ready && n < WAIT_LIMIT) begin
			@(negedge clk_in);
			n++;
		end
		if (!in_ready) begin
			errors++;
			$display("sequencer did not return to IDLE after a sample");
		end
	endtask

	initial begin
		lfsr       = 32'd88854;
		apb_req    = '0;
		pid_sum    = '0;
		data_valid = 1'b0;
		lock_en    = 1'b0;
		reset_in   = 1'b1;
		shadow_m   = PARAMS_INIT;
		active_m   = PARAMS_INIT;
		prev_m     = OUT_W'(OUT_INIT);
		repeat (10) @(posedge clk_in);
		reset_in <= 1'b0;

		check_readback();                        // reset defaults
		send_sample('0, 1'b1, 0);
		repeat (12) send_sample(small_sample(), 1'b1, 0);
		apb_write(REG_MULT, 32'd3);
		apb_write(REG_APPLY, 32'd1);
		repeat (12) send_sample(small_sample(), 1'b1, 0);
		repeat (4) send_sample(large_sample(1'b0), 1'b1, 0); // saturate high
		repeat (4) send_sample(large_sample(1'b1), 1'b1, 0); // saturate low

		apb_write(REG_INIT, 32'd1234);
		apb_write(REG_APPLY, 32'd1);
		repeat (6) send_sample(SUM_W'(random_bits(SUM_W)), 1'b0, 0); // unlocked
		repeat (4) send_sample(small_sample(), 1'b1, 0);

		apb_write(REG_MAX, 32'd5000);            // shadow only for now
		apb_write(REG_MIN, -32'sd5000);
		apb_write(REG_INIT, -32'sd300);
		apb_write(REG_MULT, 32'h0000_00FE);      // multiplier -2
		check_readback();
		repeat (2) send_sample(large_sample(1'b0), 1'b1, 0);
		apb_write(REG_APPLY, 32'd0);             // bit 0 clear, no commit
		send_sample(large_sample(1'b1), 1'b1, 0);
		apb_write(REG_APPLY, 32'd1);
		check_readback();
		send_sample('0, 1'b1, 0);
		repeat (2) send_sample(large_sample(1'b0), 1'b1, 0);
		repeat (2) send_sample(large_sample(1'b1), 1'b1, 0);
		repeat (8) send_sample(small_sample(), 1'b1, 0);

		repeat (10) send_sample(small_sample(), 1'b1, 1 + int'(random_bits(1)));

		repeat (4) @(posedge clk_in);
		if (valid_seen != accepted) begin
			errors++;
			$display("saw %0d output words for %0d accepted samples", valid_seen, accepted);
		end
		assert_fails = i_dut.i_props.fail_count;
		$display("closing: %0d check errors, %0d assertion failures, %0d words",
		         errors, assert_fails, valid_seen);
		if (errors == 0 && assert_fails == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* bench/output_preprocessor_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module output_preprocessor_properties (
	input wire                                   clk_in,
	input wire                                   reset_in,
	input wire                                   data_valid,     // sample offered
	input wire                                   in_ready,       // sequencer idle
	input wire                                   data_valid_out, // send cycle
	input wire opp_data_pkg::opp_state_e         state,          // sequencer state
	input wire signed [opp_data_pkg::OUT_W-1:0]  data_out,       // limiter register
	input wire opp_cfg_pkg::opp_params_t         params          // active set
);

	import opp_data_pkg::*;
	import opp_cfg_pkg::*;

	int unsigned fail_count = 0;                 // failures seen by the verdict

	////////////////////
	// handshake
	////////////////////

	valid_single: assert property (@(posedge clk_in) disable iff (reset_in)
		data_valid_out |=> !data_valid_out)
		else begin
			fail_count++;
			$error("data_valid_out held for two cycles");
		end

	// send cycle sits a fixed distance after acceptance
	valid_latency: assert property (@(posedge clk_in) disable iff (reset_in)
		data_valid_out |-> $past(in_ready && data_valid, COMP_LATENCY + 1))
		else begin
			fail_count++;
			$error("data_valid_out not preceded by acceptance at the compute latency");
		end

	// compute, send and done behind us
	busy_after_accept: assert property (@(posedge clk_in) disable iff (reset_in)
		$past(in_ready && data_valid, COMP_LATENCY + 3) |-> (state == IDLE))
		else begin
			fail_count++;
			$error("sequencer not back in IDLE after a sample");
		end

	busy_until_idle: assert property (@(posedge clk_in) disable iff (reset_in)
		$rose(in_ready) |-> $past(in_ready && data_valid, COMP_LATENCY + 3))
		else begin
			fail_count++;
			$error("in_ready came back before the sample finished");
		end

	////////////////////
	// output bounds
	////////////////////

	word_in_bounds: assert property (@(posedge clk_in) disable iff (reset_in)
		data_valid_out |-> ($signed(data_out) <= $signed(params.output_max) &&
		                    $signed(data_out) >= $signed(params.output_min)))
		else begin
			fail_count++;
			$error("data_out outside the active bounds");
		end

endmodule

// attached at the top, where sequencer and limiter signals meet
bind output_preprocessor_top output_preprocessor_properties i_props (
	.clk_in(clk_in), .reset_in(reset_in), .data_valid(data_valid),
	.in_ready(in_ready), .data_valid_out(data_valid_out), .state(seq_state),
	.data_out(data_out), .params(params)
);

`default_nettype wire

/* source/output_preprocessor_top.sv */
`timescale 1ns/1ps
`default_nettype none

module output_preprocessor_top (
	input  wire                                   clk_in,
	input  wire                                   reset_in,
	input  wire opp_cfg_pkg::apb_req_t            apb_req,        // config bus
	output logic [31:0]                           prdata,         // config readback
	input  wire signed [opp_data_pkg::SUM_W-1:0]  pid_sum,        // controller sum
	input  wire                                   data_valid,     // sample offered
	input  wire                                   lock_en,        // servo engaged
	output logic                                  in_ready,       // idle
	output logic signed [opp_data_pkg::OUT_W-1:0] data_out,       // dac word
	output logic                                  data_valid_out  // one cycle per word
);

	import opp_data_pkg::*;
	import opp_cfg_pkg::*;

	opp_params_t             params;             // active set
	opp_state_e              seq_state;          // probed by bound checks
	logic                    apply;              // commit pulse
	logic                    timer_start;
	logic                    timer_done;
	logic                    capture;
	logic                    load;
	logic                    latch;
	logic signed [ACC_W-1:0] sum;                // accumulator to limiter

	opp_apb_regs i_regs (
		.clk_in(clk_in), .reset_in(reset_in), .apb_req(apb_req),
		.prdata(prdata), .params(params), .apply(apply)
	);

	opp_sequencer i_seq (
		.clk_in(clk_in), .reset_in(reset_in), .data_valid(data_valid),
		.timer_done(timer_done), .in_ready(in_ready), .timer_start(timer_start),
		.capture(capture), .load(load), .latch(latch),
		.data_valid_out(data_valid_out), .state(seq_state)
	);

	opp_latency_timer i_timer (
		.clk_in(clk_in), .reset_in(reset_in), .start(timer_start), .done(timer_done)
	);

	opp_accumulator i_acc (
		.clk_in(clk_in), .reset_in(reset_in), .pid_sum(pid_sum), .capture(capture),
		.latch(latch), .apply(apply), .params(params), .data_out(data_out), .sum(sum)
	);

	opp_limiter i_lim (
		.clk_in(clk_in), .reset_in(reset_in), .sum(sum), .lock_en(lock_en),
		.load(load), .params(params), .data_out(data_out)
	);

endmodule

`default_nettype wire

/* output_stage/opp_limiter.sv */
`timescale 1ns/1ps
`default_nettype none

module opp_limiter (
	input  wire                                   clk_in,
	input  wire                                   reset_in,
	input  wire signed [opp_data_pkg::ACC_W-1:0]  sum,      // prev plus scaled
	input  wire                                   lock_en,  // low forces init
	input  wire                                   load,     // last compute cycle
	input  wire opp_cfg_pkg::opp_params_t         params,   // active set
	output logic signed [opp_data_pkg::OUT_W-1:0] data_out  // held until next load
);

	import opp_data_pkg::*;
	import opp_cfg_pkg::*;

	logic signed [ACC_W-1:0] candidate;          // locked sum or init
	logic signed [ACC_W-1:0] upper_clamped;      // after max
	logic signed [ACC_W-1:0] clamped;            // after min

	assign candidate     = lock_en ? sum : ACC_W'(params.output_init);
	assign upper_clamped = (candidate > ACC_W'(params.output_max)) ?
	                       ACC_W'(params.output_max) : candidate;
	assign clamped       = (upper_clamped < ACC_W'(params.output_min)) ?
	                       ACC_W'(params.output_min) : upper_clamped; // min wins

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			data_out <= OUT_W'(OUT_INIT);
		end else if (load) begin
			data_out <= clamped[OUT_W-1:0];      // truncate to dac width
		end
	end

endmodule

`default_nettype wire

/* output_stage/opp_accumulator.sv */
`timescale 1ns/1ps
`default_nettype none

module opp_accumulator (
	input  wire                                     clk_in,
	input  wire                                     reset_in,
	input  wire signed [opp_data_pkg::SUM_W-1:0]    pid_sum,  // controller sum
	input  wire                                     capture,  // take pid_sum
	input  wire                                     latch,    // take data_out
	input  wire                                     apply,    // reload from init
	input  wire opp_cfg_pkg::opp_params_t           params,   // active set
	input  wire signed [opp_data_pkg::OUT_W-1:0]    data_out, // limiter register
	output logic signed [opp_data_pkg::ACC_W-1:0]   sum       // to the limiter
);

	import opp_data_pkg::*;
	import opp_cfg_pkg::*;

	logic signed [SUM_W-1:0]       pid_q;        // captured sample
	logic signed [OUT_W-1:0]       prev_out;     // last issued word
	logic signed [SUM_W+MLT_W-1:0] scaled;       // sample times multiplier

	////////////////////
	// sample capture
	////////////////////

	always_ff @(posedge clk_in) begin
		if (capture) begin
			pid_q <= pid_sum;
		end
	end

	// apply has priority over the done latch
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			prev_out <= OUT_W'(OUT_INIT);
		end else if (apply) begin
			prev_out <= params.output_init;      // restart from new init
		end else if (latch) begin
			prev_out <= data_out;                // word just sent
		end
	end

	////////////////////
	// scale and add
	////////////////////

	assign scaled = pid_q * $signed(params.multiplier);
	assign sum    = ACC_W'(scaled) + ACC_W'(prev_out); // both sign extended

endmodule

`default_nettype wire

/* output_stage/opp_latency_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module opp_latency_timer (
	input  wire  clk_in,
	input  wire  reset_in,
	input  wire  start,                          // sample accepted
	output logic done                            // final compute cycle
);

	import opp_data_pkg::*;

	logic [TMR_W-1:0] count;                     // cycles left minus one
	logic             running;                   // compute phase active

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			count   <= '0;
			running <= 1'b0;
		end else if (start) begin
			count   <= TMR_W'(COMP_LATENCY - 1);
			running <= 1'b1;
		end else if (running) begin
			if (count == '0) begin
				running <= 1'b0;                 // phase over
			end else begin
				count <= count - 1'b1;
			end
		end
	end

	assign done = running & (count == '0);

endmodule

`default_nettype wire

/* output_stage/opp_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module opp_sequencer (
	input  wire                      clk_in,
	input  wire                      reset_in,
	input  wire                      data_valid,     // sample offered
	input  wire                      timer_done,     // last compute cycle
	output logic                     in_ready,       // idle, sample accepted
	output logic                     timer_start,    // arm latency timer
	output logic                     capture,        // register pid_sum
	output logic                     load,           // register limiter output
	output logic                     latch,          // data_out becomes prev output
	output logic                     data_valid_out, // word valid to dac
	output opp_data_pkg::opp_state_e state           // for bound checks
);

	import opp_data_pkg::*;

	opp_state_e next_state;                          // comb next state

	////////////////////
	// state register
	////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;                          // hold by default
		case (state)
			IDLE:    if (data_valid) next_state = COMPUTE;
			COMPUTE: if (timer_done) next_state = SEND;
			SEND:    next_state = DONE;              // single valid cycle
			DONE:    next_state = IDLE;
			default: next_state = IDLE;
		endcase
	end

	////////////////////
	// strobes
	////////////////////

	assign in_ready       = (state == IDLE);
	assign capture        = in_ready & data_valid;   // acceptance edge
	assign timer_start    = capture;                 // timer runs from acceptance
	assign load           = (state == COMPUTE) & timer_done;
	assign data_valid_out = (state == SEND);
	assign latch          = (state == DONE);

endmodule

`default_nettype wire

/* output_stage/opp_apb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module opp_apb_regs (
	input  wire                       clk_in,
	input  wire                       reset_in,
	input  wire opp_cfg_pkg::apb_req_t apb_req,   // from the apb master
	output logic [31:0]               prdata,     // shadow readback
	output opp_cfg_pkg::opp_params_t  params,     // active set to the datapath
	output logic                      apply       // one cycle after commit
);

	import opp_data_pkg::*;
	import opp_cfg_pkg::*;

	opp_params_t shadow;                          // written over apb
	opp_reg_e    reg_addr;                        // decoded word address
	logic        wr_access;                       // write in access phase
	logic        rd_access;                       // read in access phase
	logic        apply_hit;                       // commit request this edge

	////////////////////
	// access decode
	////////////////////

	assign reg_addr  = opp_reg_e'(apb_req.paddr);
	assign wr_access = apb_req.psel & apb_req.penable & apb_req.pwrite;
	assign rd_access = apb_req.psel & apb_req.penable & ~apb_req.pwrite;
	assign apply_hit = wr_access & (reg_addr == REG_APPLY) & apb_req.pwdata[0];

	// shadow set, takes effect at end of access cycle
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			shadow <= PARAMS_INIT;
		end else if (wr_access) begin
			case (reg_addr)
				REG_MAX:  shadow.output_max  <= apb_req.pwdata[OUT_W-1:0];
				REG_MIN:  shadow.output_min  <= apb_req.pwdata[OUT_W-1:0];
				REG_INIT: shadow.output_init <= apb_req.pwdata[OUT_W-1:0];
				REG_MULT: shadow.multiplier  <= apb_req.pwdata[MLT_W-1:0];
				default:  ;                       // apply and holes store nothing
			endcase
		end
	end

	////////////////////
	// active set
	////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			params <= PARAMS_INIT;
			apply  <= 1'b0;
		end else begin
			apply <= apply_hit;                   // pulse seen with new set in place
			if (apply_hit) begin
				params <= shadow;                 // whole set commits at once
			end
		end
	end

	// readback, sign extended to the bus
	always_comb begin
		prdata = '0;
		if (rd_access) begin
			case (reg_addr)
				REG_MAX:  prdata = 32'(shadow.output_max);
				REG_MIN:  prdata = 32'(shadow.output_min);
				REG_INIT: prdata = 32'(shadow.output_init);
				REG_MULT: prdata = 32'(shadow.multiplier);
				default:  prdata = '0;            // apply reads as zero
			endcase
		end
	end

endmodule

`default_nettype wire

/* common/opp_cfg_pkg.sv */
`default_nettype none

package opp_cfg_pkg;

	// one full parameter set, shadow and active use the same layout
	typedef struct packed {
		logic signed [opp_data_pkg::OUT_W-1:0] output_max;  // upper clamp
		logic signed [opp_data_pkg::OUT_W-1:0] output_min;  // lower clamp
		logic signed [opp_data_pkg::OUT_W-1:0] output_init; // unlocked / reload value
		logic signed [opp_data_pkg::MLT_W-1:0] multiplier;  // sample scale
	} opp_params_t;

	typedef struct packed {
		logic        psel;                           // slave select
		logic        penable;                        // access phase
		logic        pwrite;                         // 1 for write
		logic [4:0]  paddr;                          // byte address of the word
		logic [31:0] pwdata;                         // write data
	} apb_req_t;

	typedef enum logic [4:0] {
		REG_MAX   = 5'h00,                           // shadow output_max
		REG_MIN   = 5'h04,                           // shadow output_min
		REG_INIT  = 5'h08,                           // shadow output_init
		REG_MULT  = 5'h0C,                           // shadow multiplier
		REG_APPLY = 5'h10                            // bit 0 commits shadow set
	} opp_reg_e;

	localparam int MAX_INIT = 20000;                 // reset upper bound
	localparam int MIN_INIT = -20000;                // reset lower bound
	localparam int OUT_INIT = 0;                     // reset initial output
	localparam int MLT_INIT = 1;                     // reset multiplier

	localparam opp_params_t PARAMS_INIT = '{
		output_max:  (opp_data_pkg::OUT_W)'(MAX_INIT),
		output_min:  (opp_data_pkg::OUT_W)'(MIN_INIT),
		output_init: (opp_data_pkg::OUT_W)'(OUT_INIT),
		multiplier:  (opp_data_pkg::MLT_W)'(MLT_INIT)
	};

endpackage

`default_nettype wire

/* common/opp_data_pkg.sv */
`default_nettype none

package opp_data_pkg;

	////////////////////
	// datapath widths
	////////////////////

	localparam int SUM_W = 24;                       // controller sum from the pid
	localparam int OUT_W = 16;                       // dac / dds word and bounds
	localparam int MLT_W = 8;                        // signed output multiplier
	localparam int ACC_W = SUM_W + MLT_W + 1;        // scaled sample plus prev output

	////////////////////
	// compute timing
	////////////////////

	localparam int COMP_LATENCY = 2;                 // cycles spent in compute
	localparam int TMR_W = $clog2(COMP_LATENCY + 1); // latency counter width

	// one sample in flight, so four states are enough
	typedef enum logic [1:0] {
		IDLE    = 2'd0,                              // waiting for a sample
		COMPUTE = 2'd1,                              // datapath settling
		SEND    = 2'd2,                              // word valid downstream
		DONE    = 2'd3                               // prev output latched
	} opp_state_e;

endpackage

`default_nettype wire
